/* tests/bridge_testdata.txt */
// in: ctl state addr_in data_in cpu_index ext_msg_in int_msg_in
// exp: ctl ext_msg int_msg_out base_addr base_addr_data addr_out data_out, then check mask
00 18 000 000 3 0 0  000 0 0 000 000 000 000  b
00 18 000 000 3 0 0  000 0 0 000 000 000 000  b
00 18 000 000 3 0 0  000 0 0 000 000 000 000  b
00 18 000 000 3 0 0  380 1 0 000 000 000 000  b
00 18 000 000 3 0 0  040 0 0 000 000 000 000  b
00 18 000 000 3 0 0  040 0 0 000 000 000 000  b
04 00 100 000 5 0 0  000 0 0 000 000 000 000  b
0c 00 100 000 3 0 0  000 0 0 000 000 000 000  b
04 00 100 000 3 0 0  000 0 0 000 000 000 000  b
00 00 200 300 3 0 0  038 2 0 110 110 000 000  f
04 00 200 300 3 0 0  000 0 0 110 110 000 000  f
00 18 000 000 3 0 0  038 2 0 210 310 000 000  f
04 08 000 000 3 0 0  000 0 0 210 310 000 000  f
40 08 000 000 3 0 0  064 0 0 210 310 000 000  f
20 08 000 000 3 0 0  068 0 0 210 310 000 000  f
40 08 000 000 3 0 0  040 0 0 210 310 000 000  f
24 0d 000 000 3 0 0  040 0 0 210 310 000 000  f
10 0d 000 000 3 0 0  060 0 0 210 310 000 000  f
20 0d 000 000 3 0 0  06a 0 0 210 310 000 000  f
00 18 000 000 3 0 0  040 0 0 210 310 000 000  f
05 08 000 000 3 0 0  000 0 0 210 310 000 000  f
01 08 000 000 3 0 0  060 0 0 210 310 000 000  f
01 08 000 000 3 0 0  060 0 0 210 310 000 000  f
01 08 000 000 3 0 0  060 0 0 210 310 000 000  f
01 08 000 000 3 0 0  060 0 0 210 310 000 000  f
01 08 000 000 3 0 0  060 0 0 210 310 000 000  f
00 08 000 000 3 0 0  061 0 0 210 310 000 000  f
02 08 000 000 3 0 0  071 0 0 210 310 000 000  f
00 08 000 000 3 0 0  070 0 0 210 310 000 000  f
40 08 000 000 3 0 0  064 0 0 210 310 000 000  f
00 18 000 000 3 0 0  068 0 0 210 310 000 000  f
00 18 000 000 3 7 5  000 5 7 210 310 000 000  f
04 15 000 000 3 8 6  000 6 8 210 310 000 000  f
00 15 000 000 3 0 0  078 4 0 210 310 210 310  f
00 18 000 000 3 0 5  040 5 0 210 310 000 000  f
00 12 000 000 3 7 0  000 0 7 210 310 000 000  f
00 18 000 000 3 0 0  008 0 0 210 310 000 000  f
04 13 000 000 3 0 0  000 0 0 210 310 000 000  f
00 14 000 000 3 0 0  078 3 0 210 310 000 000  f
00 18 000 000 7 0 0  000 0 0 210 310 000 000  f
00 18 000 000 7 0 0  000 0 0 210 310 000 000  f
00 18 000 000 7 0 0  300 0 0 210 310 000 000  f
00 18 000 000 7 0 0  040 0 0 210 310 000 000  f
00 18 000 000 7 0 0  040 0 0 210 310 000 000  f
04 00 400 000 3 0 0  000 0 0 210 310 000 000  f
00 18 000 000 3 0 0  038 2 0 410 410 000 000  f
00 18 000 000 3 0 0  000 0 0 410 410 000 000  f

/* sources.f */
logic/bridge_pkg.sv
logic/ring_ctrl_if.sv
logic/reset_sequencer.sv
logic/dispatch_ctrl.sv
logic/idle_timer.sv
logic/bridge_top.sv
tests/bridge_tb.sv

/* Bender.yml */
package:
  name: bridge

sources:
  - logic/bridge_pkg.sv
  - logic/ring_ctrl_if.sv
  - logic/reset_sequencer.sv
  - logic/dispatch_ctrl.sv
  - logic/idle_timer.sv
  - logic/bridge_top.sv
  - target: test
    files:
      - tests/bridge_tb.sv

/* tests/bridge_tb.sv */
`default_nettype none

module bridge_tb;

  // one step per data line, 15 hex words each
  localparam int FIELDS    = 15;
  localparam int MAX_STEPS = 64;
  localparam int PERIOD    = 40;

  logic                   clk;
  logic                   ext_rst_b;
  bridge_pkg::cpu_state_e state;
  bridge_pkg::addr_t      addr_in;
  bridge_pkg::data_t      data_in;
  logic                   read_q;
  logic                   write_q;
  logic                   chan_op;
  logic                   bus_busy_in;
  logic                   ext_next_cpu_q;
  bridge_pkg::data_t      ext_cpu_index;
  bridge_pkg::cpu_msg_e   ext_cpu_msg_in;
  bridge_pkg::cpu_msg_e   int_cpu_msg_in;
  logic                   no_data_new;
  logic                   no_data_tick;
  bridge_pkg::addr_t      base_addr;
  bridge_pkg::addr_t      base_addr_data;
  bridge_pkg::addr_t      addr_out;
  bridge_pkg::data_t      data_out;
  logic                   bus_busy_out;
  logic                   disp_online;
  logic                   next_state;
  logic                   rst;
  logic                   ext_rst_e;
  logic                   ext_next_cpu_e;
  logic                   ext_dispatcher_q;
  logic                   ext_read_q;
  logic                   ext_write_q;
  bridge_pkg::cpu_msg_e   ext_cpu_msg;
  bridge_pkg::cpu_msg_e   int_cpu_msg_out;
  logic                   no_data_exit_and_wait_begin;

  // raw words of the data file
  logic [31:0] tdata [0:FIELDS*MAX_STEPS-1];
  int          n_steps;
  int          n_checks;
  int          n_errors;
  bit          loaded;
  integer      seed;

  bridge_top dut_i (.*);

  initial begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  task automatic check_bit(input string name, input logic got, input logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input bridge_pkg::addr_t got,
                            input bridge_pkg::addr_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input bridge_pkg::data_t got,
                            input bridge_pkg::data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_msg(input string name, input bridge_pkg::cpu_msg_e got,
                           input bridge_pkg::cpu_msg_e exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  // word 0 bits: read_q write_q chan_op bus_busy_in next_cpu_q no_data_new no_data_tick
  task automatic apply_step(input int k);
    int b;
    b = k * FIELDS;
    {read_q, write_q, chan_op, bus_busy_in, ext_next_cpu_q, no_data_new, no_data_tick} =
      tdata[b][6:0];
    state          = bridge_pkg::cpu_state_e'(tdata[b+1][5:0]);
    addr_in        = tdata[b+2];
    data_in        = tdata[b+3];
    ext_cpu_index  = tdata[b+4];
    ext_cpu_msg_in = bridge_pkg::cpu_msg_e'(tdata[b+5][7:0]);
    int_cpu_msg_in = bridge_pkg::cpu_msg_e'(tdata[b+6][7:0]);
  endtask

  // mask bits: control, messages, base addresses, bus addresses
  task automatic check_step(input int k);
    int         b;
    logic [9:0] ec;
    logic [3:0] mk;
    b  = k * FIELDS;
    ec = tdata[b+7][9:0];
    mk = tdata[b+14][3:0];
    if (mk[0]) begin
      check_bit("bus_busy_out", bus_busy_out, ec[9]);
      check_bit("rst", rst, ec[8]);
      check_bit("ext_rst_e", ext_rst_e, ec[7]);
      check_bit("ext_dispatcher_q", ext_dispatcher_q, ec[6]);
      check_bit("disp_online", disp_online, ec[5]);
      check_bit("next_state", next_state, ec[4]);
      check_bit("ext_next_cpu_e", ext_next_cpu_e, ec[3]);
      check_bit("ext_read_q", ext_read_q, ec[2]);
      check_bit("ext_write_q", ext_write_q, ec[1]);
      check_bit("no_data_exit_and_wait_begin", no_data_exit_and_wait_begin, ec[0]);
    end
    if (mk[1]) begin
      check_msg("ext_cpu_msg", ext_cpu_msg, bridge_pkg::cpu_msg_e'(tdata[b+8][7:0]));
      check_msg("int_cpu_msg_out", int_cpu_msg_out, bridge_pkg::cpu_msg_e'(tdata[b+9][7:0]));
    end
    if (mk[2]) begin
      check_addr("base_addr", base_addr, tdata[b+10]);
      check_addr("base_addr_data", base_addr_data, tdata[b+11]);
    end
    if (mk[3]) begin
      check_addr("addr_out", addr_out, tdata[b+12]);
      check_data("data_out", data_out, tdata[b+13]);
    end
  endtask

  initial begin : stimulus
    seed           = 15;
    n_steps        = 0;
    n_checks       = 0;
    n_errors       = 0;
    loaded         = 1'b0;
    ext_rst_b      = 1'b1;
    read_q         = 1'b0;
    write_q        = 1'b0;
    chan_op        = 1'b0;
    bus_busy_in    = 1'b0;
    ext_next_cpu_q = 1'b0;
    no_data_new    = 1'b0;
    no_data_tick   = 1'b0;
    state          = bridge_pkg::IDLE;
    ext_cpu_msg_in = bridge_pkg::MSG_NONE;
    int_cpu_msg_in = bridge_pkg::MSG_NONE;
    // bus values are don't care under reset
    addr_in        = $random(seed);
    data_in        = $random(seed);
    ext_cpu_index  = $random(seed);
    $readmemh("tests/bridge_testdata.txt", tdata);
    // a step counts once its mask word is present
    while (n_steps < MAX_STEPS && !$isunknown(tdata[n_steps*FIELDS + FIELDS - 1])) begin
      n_steps++;
    end
    loaded = 1'b1;
    if (n_steps == 0) begin
      n_errors++;
      $display("no test steps could be read from tests/bridge_testdata.txt");
    end
    repeat (2) @(posedge clk);
    #2;
    ext_rst_b = 1'b0;
    // drive just after the edge, sample just before the next one
    for (int k = 0; k < n_steps; k++) begin
      apply_step(k);
      #(PERIOD - 4);
      check_step(k);
      @(posedge clk);
      #2;
    end
    $display("steps: %0d, checks: %0d, errors: %0d", n_steps, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    // one period per step, reset cycles and some slack
    #((n_steps + 12) * PERIOD);
    $display("timeout: the test steps did not complete in the expected time");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/bridge_top.sv */
`default_nettype none

module bridge_top #(
  parameter bridge_pkg::addr_t THREAD_HEADER_SPACE = 16,
  parameter logic [7:0]        NO_DATA_COUNT_MAX   = 8'd5
) (
  input  logic                  clk,
  input  logic                  ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  input  bridge_pkg::addr_t     addr_in,
  input  bridge_pkg::data_t     data_in,
  input  logic                  read_q,
  input  logic                  write_q,
  input  logic                  chan_op,
  input  logic                  bus_busy_in,
  input  logic                  ext_next_cpu_q,
  input  bridge_pkg::data_t     ext_cpu_index,
  input  bridge_pkg::cpu_msg_e  ext_cpu_msg_in,
  input  bridge_pkg::cpu_msg_e  int_cpu_msg_in,
  input  logic                  no_data_new,
  input  logic                  no_data_tick,
  output bridge_pkg::addr_t     base_addr,
  output bridge_pkg::addr_t     base_addr_data,
  output bridge_pkg::addr_t     addr_out,
  output bridge_pkg::data_t     data_out,
  output logic                  bus_busy_out,
  output logic                  disp_online,
  output logic                  next_state,
  output logic                  rst,
  output logic                  ext_rst_e,
  output logic                  ext_next_cpu_e,
  output logic                  ext_dispatcher_q,
  output logic                  ext_read_q,
  output logic                  ext_write_q,
  output bridge_pkg::cpu_msg_e  ext_cpu_msg,
  output bridge_pkg::cpu_msg_e  int_cpu_msg_out,
  output logic                  no_data_exit_and_wait_begin
);

  // finish seen by dispatch, sends the sequencer back to step one
  logic back_to_start;

  ring_ctrl_if ring ();

  reset_sequencer u_seq (
    .clk           (clk),
    .ext_rst_b     (ext_rst_b),
    .ext_cpu_index (ext_cpu_index),
    .back_to_start (back_to_start),
    .rst           (rst),
    .ext_rst_e     (ext_rst_e),
    .bus_busy_out  (bus_busy_out),
    .ring          (ring.seq)
  );

  dispatch_ctrl #(
    .THREAD_HEADER_SPACE (THREAD_HEADER_SPACE)
  ) u_disp (
    .clk                         (clk),
    .ext_rst_b                   (ext_rst_b),
    .state                       (state),
    .addr_in                     (addr_in),
    .data_in                     (data_in),
    .read_q                      (read_q),
    .write_q                     (write_q),
    .chan_op                     (chan_op),
    .bus_busy_in                 (bus_busy_in),
    .ext_next_cpu_q              (ext_next_cpu_q),
    .ext_cpu_index               (ext_cpu_index),
    .ext_cpu_msg_in              (ext_cpu_msg_in),
    .int_cpu_msg_in              (int_cpu_msg_in),
    .no_data_exit_and_wait_begin (no_data_exit_and_wait_begin),
    .ring                        (ring.disp),
    .base_addr                   (base_addr),
    .base_addr_data              (base_addr_data),
    .addr_out                    (addr_out),
    .data_out                    (data_out),
    .disp_online                 (disp_online),
    .next_state                  (next_state),
    .ext_next_cpu_e              (ext_next_cpu_e),
    .ext_dispatcher_q            (ext_dispatcher_q),
    .ext_read_q                  (ext_read_q),
    .ext_write_q                 (ext_write_q),
    .ext_cpu_msg                 (ext_cpu_msg),
    .int_cpu_msg_out             (int_cpu_msg_out),
    .back_to_start               (back_to_start)
  );

  // idle counting only while the bridge runs
  idle_timer #(
    .NO_DATA_COUNT_MAX (NO_DATA_COUNT_MAX)
  ) u_idle (
    .clk                         (clk),
    .ext_rst_b                   (ext_rst_b),
    .running                     (ring.running),
    .no_data_new                 (no_data_new),
    .no_data_tick                (no_data_tick),
    .no_data_exit_and_wait_begin (no_data_exit_and_wait_begin)
  );

endmodule

`default_nettype wire

/* logic/idle_timer.sv */
`default_nettype none

module idle_timer #(
  parameter logic [7:0] NO_DATA_COUNT_MAX = 8'd5
) (
  input  logic clk,
  input  logic ext_rst_b,
  input  logic running,
  input  logic no_data_new,
  input  logic no_data_tick,
  output logic no_data_exit_and_wait_begin
);

  // ticks seen since the last data
  logic [7:0] no_data_cntr;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      no_data_cntr                <= '0;
      no_data_exit_and_wait_begin <= 1'b0;
    end else if (!running || no_data_new) begin
      // fresh data or start-up restarts the wait
      no_data_cntr                <= '0;
      no_data_exit_and_wait_begin <= 1'b0;
    end else if (no_data_tick) begin
      if (no_data_cntr >= NO_DATA_COUNT_MAX) begin
        // waited long enough, read gives up
        no_data_cntr                <= '0;
        no_data_exit_and_wait_begin <= 1'b1;
      end else begin
        no_data_cntr <= no_data_cntr + 8'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/dispatch_ctrl.sv */
`default_nettype none

module dispatch_ctrl #(
  parameter bridge_pkg::addr_t THREAD_HEADER_SPACE = 16
) (
  input  logic                   clk,
  input  logic                   ext_rst_b,
  input  bridge_pkg::cpu_state_e state,
  input  bridge_pkg::addr_t      addr_in,
  input  bridge_pkg::data_t      data_in,
  input  logic                   read_q,
  input  logic                   write_q,
  input  logic                   chan_op,
  input  logic                   bus_busy_in,
  input  logic                   ext_next_cpu_q,
  input  bridge_pkg::data_t      ext_cpu_index,
  input  bridge_pkg::cpu_msg_e   ext_cpu_msg_in,
  input  bridge_pkg::cpu_msg_e   int_cpu_msg_in,
  input  logic                   no_data_exit_and_wait_begin,
  ring_ctrl_if.disp              ring,
  output bridge_pkg::addr_t      base_addr,
  output bridge_pkg::addr_t      base_addr_data,
  output bridge_pkg::addr_t      addr_out,
  output bridge_pkg::data_t      data_out,
  output logic                   disp_online,
  output logic                   next_state,
  output logic                   ext_next_cpu_e,
  output logic                   ext_dispatcher_q,
  output logic                   ext_read_q,
  output logic                   ext_write_q,
  output bridge_pkg::cpu_msg_e   ext_cpu_msg,
  output bridge_pkg::cpu_msg_e   int_cpu_msg_out,
  output logic                   back_to_start
);

  bridge_pkg::cpu_msg_e msg_r;
  bridge_pkg::addr_t    start_base;
  logic dq_r;
  logic run_q;
  logic live;
  logic boot;
  logic rd_st;
  logic wr_st;
  logic token_hit;
  logic return_stim;
  logic done_in;

  assign rd_st       = bridge_pkg::is_read_state(state);
  assign wr_st       = bridge_pkg::is_write_state(state);
  assign token_hit   = ext_next_cpu_q && (ext_cpu_index == ring.cpu_index);
  // give the token back once the bus has been used
  assign return_stim = (read_q || write_q || chan_op) && disp_online && !ext_next_cpu_e;
  assign done_in     = (ext_cpu_msg_in == bridge_pkg::MSG_FORK_DONE) ||
                       (ext_cpu_msg_in == bridge_pkg::MSG_STOP_DONE);
  // restart pulse drops the bridge back to start-up handling
  assign live        = run_q && !ring.restart;
  // last start-up step, dispatcher request goes up early
  assign boot        = ring.running && !run_q;
  assign start_base  = addr_in + THREAD_HEADER_SPACE;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      msg_r          <= bridge_pkg::MSG_NONE;
      dq_r           <= 1'b0;
      run_q          <= 1'b0;
      disp_online    <= 1'b0;
      next_state     <= 1'b0;
      ext_next_cpu_e <= 1'b0;
    end else begin
      run_q      <= ring.running;
      next_state <= 1'b0;
      if (!live) begin
        // offline, a matching token goes straight back
        disp_online    <= 1'b0;
        dq_r           <= boot;
        ext_next_cpu_e <= token_hit;
        msg_r          <= (ring.reset_msg && !ring.finish_seen) ?
                          bridge_pkg::MSG_RESET : bridge_pkg::MSG_NONE;
      end else begin
        // token handed back, offline one cycle later
        if (ext_next_cpu_e) begin
          disp_online <= 1'b0;
        end
        // busy bus freezes the token logic
        if (!bus_busy_in) begin
          msg_r          <= bridge_pkg::MSG_NONE;
          ext_next_cpu_e <= return_stim;
          if (token_hit) begin
            disp_online <= 1'b1;
          end
          if (rd_st) begin
            dq_r       <= 1'b1;
            // give up a read with no data
            next_state <= no_data_exit_and_wait_begin;
          end else if (wr_st) begin
            dq_r <= 1'b1;
          end else begin
            case (state)
              bridge_pkg::WAIT_FOR_START: begin
                if (token_hit) begin
                  msg_r          <= bridge_pkg::MSG_START;
                  ext_next_cpu_e <= 1'b1;
                  next_state     <= 1'b1;
                end else begin
                  dq_r <= 1'b0;
                end
              end
              bridge_pkg::FINISH_BEGIN: begin
                dq_r <= 1'b1;
                if (token_hit) begin
                  msg_r          <= bridge_pkg::MSG_END;
                  ext_next_cpu_e <= 1'b1;
                  next_state     <= 1'b1;
                end
              end
              bridge_pkg::BREAK_THREAD_SAVE_IP_AND_WAIT,
              bridge_pkg::BREAK_THREAD_EXIT_AND_WAIT: begin
                if (token_hit) begin
                  msg_r          <= bridge_pkg::MSG_BREAK_THREAD;
                  dq_r           <= 1'b1;
                  ext_next_cpu_e <= 1'b1;
                  next_state     <= 1'b1;
                end
              end
              bridge_pkg::AUX_PRE_FINISH_BEGIN: begin
                if (token_hit) begin
                  dq_r           <= 1'b1;
                  ext_next_cpu_e <= 1'b1;
                  next_state     <= 1'b1;
                end
              end
              // fork or stop completed elsewhere
              bridge_pkg::ALU_BEGIN: ext_next_cpu_e <= done_in;
              default: dq_r <= 1'b0;
            endcase
          end
        end
      end
    end
  end

  // thread base addresses, taken when a thread starts
  always_ff @(posedge clk) begin
    if (live && !bus_busy_in && token_hit && state == bridge_pkg::WAIT_FOR_START) begin
      base_addr      <= start_base;
      base_addr_data <= (data_in == '0) ? start_base : data_in + THREAD_HEADER_SPACE;
    end
  end

  // base addresses on the bus only with a break message
  assign addr_out = (msg_r == bridge_pkg::MSG_BREAK_THREAD) ? base_addr : '0;
  assign data_out = (msg_r == bridge_pkg::MSG_BREAK_THREAD) ? base_addr_data : '0;

  assign ext_read_q       = (rd_st && disp_online) ? read_q : 1'b0;
  assign ext_write_q      = (wr_st && disp_online) ? write_q : 1'b0;
  assign ext_dispatcher_q = dq_r || boot;
  assign back_to_start    = (state == bridge_pkg::FINISH_END) && run_q;

  // fork and stop from the core win over the own message
  assign ext_cpu_msg = (int_cpu_msg_in == bridge_pkg::MSG_FORK_THRD ||
                        int_cpu_msg_in == bridge_pkg::MSG_STOP_THRD) ? int_cpu_msg_in : msg_r;
  assign int_cpu_msg_out = done_in ? ext_cpu_msg_in : bridge_pkg::MSG_NONE;

endmodule

`default_nettype wire

/* logic/reset_sequencer.sv */
`default_nettype none

module reset_sequencer (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  bridge_pkg::data_t ext_cpu_index,
  input  logic              back_to_start,
  output logic              rst,
  output logic              ext_rst_e,
  output logic              bus_busy_out,
  ring_ctrl_if.seq          ring
);

  // start-up steps, one per clock
  typedef enum logic [2:0] {
    STEP_1,
    STEP_2,
    STEP_3,
    STEP_4,
    STEP_5,
    STEP_RUN
  } step_e;

  step_e             step;
  bridge_pkg::data_t cpu_index;
  logic              running;
  logic              reset_msg;
  logic              restart;
  logic              finish_seen;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step         <= STEP_1;
      rst          <= 1'b0;
      ext_rst_e    <= 1'b0;
      bus_busy_out <= 1'b0;
      running      <= 1'b0;
      reset_msg    <= 1'b0;
      restart      <= 1'b0;
      finish_seen  <= 1'b0;
    end else begin
      // pulses drop after one cycle
      reset_msg <= 1'b0;
      restart   <= 1'b0;
      case (step)
        STEP_1: step <= STEP_2;
        STEP_2: begin
          if (finish_seen) begin
            // after a finish go straight to the reset pulse
            rst          <= 1'b1;
            bus_busy_out <= 1'b1;
            step         <= STEP_4;
          end else begin
            reset_msg <= 1'b1;
            step      <= STEP_3;
          end
        end
        STEP_3: begin
          // external reset only on a fresh start
          rst          <= 1'b1;
          ext_rst_e    <= 1'b1;
          bus_busy_out <= 1'b1;
          step         <= STEP_4;
        end
        STEP_4: begin
          rst          <= 1'b0;
          ext_rst_e    <= 1'b0;
          bus_busy_out <= 1'b0;
          // dispatch side registers this once more
          running      <= 1'b1;
          step         <= STEP_5;
        end
        STEP_5: begin
          finish_seen <= 1'b0;
          step        <= STEP_RUN;
        end
        default: begin
          // thread finished, redo start-up without a new index
          if (back_to_start) begin
            running     <= 1'b0;
            restart     <= 1'b1;
            finish_seen <= 1'b1;
            step        <= STEP_1;
          end
        end
      endcase
    end
  end

  // ring index taken once per fresh start-up
  always_ff @(posedge clk) begin
    if (step == STEP_3) begin
      cpu_index <= ext_cpu_index;
    end
  end

  assign ring.running     = running;
  assign ring.cpu_index   = cpu_index;
  assign ring.reset_msg   = reset_msg;
  assign ring.restart     = restart;
  assign ring.finish_seen = finish_seen;

endmodule

`default_nettype wire

/* logic/ring_ctrl_if.sv */
`default_nettype none

// start-up status handed from the sequencer to the dispatch side
interface ring_ctrl_if;

  // start-up done, bridge may serve the token
  logic              running;
  // ring index captured during start-up
  bridge_pkg::data_t cpu_index;
  // single cycle, ask for a reset message on the ring
  logic              reset_msg;
  // single cycle on return to step one
  logic              restart;
  // current start-up follows a finished thread
  logic              finish_seen;

  modport seq (
    output running,
    output cpu_index,
    output reset_msg,
    output restart,
    output finish_seen
  );

  modport disp (
    input running,
    input cpu_index,
    input reset_msg,
    input restart,
    input finish_seen
  );

endinterface

`default_nettype wire

/* logic/bridge_pkg.sv */
`default_nettype none

package bridge_pkg;

  // address and data paths of the ring bus
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  // data word, also carries the ring index
  typedef logic [DATA_W-1:0] data_t;

  // processor FSM state as seen on the state port
  typedef enum logic [5:0] {
    WAIT_FOR_START,
    READ_MEM_SIZE_1,
    START_READ_CMD,
    START_READ_CMD_P,
    READ_COND,
    READ_COND_P,
    READ_SRC1,
    READ_SRC1_P,
    READ_SRC0,
    READ_SRC0_P,
    READ_DST,
    READ_DST_P,
    WRITE_REG_IP,
    WRITE_DST,
    WRITE_DST_P,
    WRITE_SRC1,
    WRITE_SRC0,
    WRITE_COND,
    ALU_BEGIN,
    FINISH_BEGIN,
    FINISH_END,
    BREAK_THREAD_SAVE_IP_AND_WAIT,
    BREAK_THREAD_EXIT_AND_WAIT,
    AUX_PRE_FINISH_BEGIN,
    IDLE
  } cpu_state_e;

  // messages between processors and dispatcher
  typedef enum logic [7:0] {
    MSG_NONE         = 8'd0,
    MSG_RESET        = 8'd1,
    MSG_START        = 8'd2,
    MSG_END          = 8'd3,
    MSG_BREAK_THREAD = 8'd4,
    MSG_FORK_THRD    = 8'd5,
    MSG_STOP_THRD    = 8'd6,
    MSG_FORK_DONE    = 8'd7,
    MSG_STOP_DONE    = 8'd8
  } cpu_msg_e;

  // states that fetch from memory through the dispatcher
  function automatic logic is_read_state(cpu_state_e st);
    return st inside {READ_MEM_SIZE_1, START_READ_CMD, START_READ_CMD_P,
                      READ_COND, READ_COND_P, READ_SRC1, READ_SRC1_P,
                      READ_SRC0, READ_SRC0_P, READ_DST, READ_DST_P};
  endfunction

  // states that store results through the dispatcher
  function automatic logic is_write_state(cpu_state_e st);
    return st inside {WRITE_REG_IP, WRITE_DST, WRITE_DST_P,
                      WRITE_SRC1, WRITE_SRC0, WRITE_COND};
  endfunction

endpackage

`default_nettype wire
